/* rtl/mmio_pkg.sv */
package mmio_pkg;

    // bus geometry
    localparam int addr_width = 16;
    localparam int data_width = 64;
    localparam int byte_lanes = data_width / 8;

    // data ram, 4 KiB of doublewords
    localparam int ram_words = 512;
    localparam int ram_addr_width = $clog2(ram_words);
    localparam logic [addr_width-1:0] ram_base = 16'h0000;
    localparam logic [addr_width-1:0] ram_len = 16'h1000;

    // one doubleword slot per peripheral
    localparam logic [addr_width-1:0] kbd_addr = 16'h1000;
    localparam logic [addr_width-1:0] swt_addr = 16'h1008;
    localparam logic [addr_width-1:0] rtc_addr = 16'h1010;
    localparam logic [addr_width-1:0] seg_addr = 16'h1018;
    localparam logic [addr_width-1:0] led_addr = 16'h1020;
    localparam logic [addr_width-1:0] periph_len = 16'd8;

    // peripheral field widths
    localparam int kb_width = 8;
    localparam int swt_width = 8;
    localparam int seg_width = 32;
    localparam int led_width = 16;
    localparam int rtc_width = 32;

    // clocks per real-time tick
    localparam int rtc_div = 4;

    // store access size, loads always return a full doubleword
    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_half  = 2'd1,
        size_word  = 2'd2,
        size_dword = 2'd3
    } size_t;

    // bus masters, core wins a collision
    typedef enum logic {
        master_core = 1'b0,
        master_host = 1'b1
    } master_t;

    // one-cycle strobe request
    typedef struct packed {
        logic                  strobe;
        logic                  write;
        size_t                 size;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
        master_t               master;
    } mmio_req_t;

    // read response, tagged with the asking master
    typedef struct packed {
        logic                  valid;
        logic                  fault;
        master_t               master;
        logic [data_width-1:0] rdata;
    } mmio_rsp_t;

endpackage

/* rtl/bus_arbiter.sv */
module bus_arbiter (
    input  logic                clk,
    input  logic                reset,
    input  mmio_pkg::mmio_req_t core_req,
    input  mmio_pkg::mmio_req_t host_req,
    output mmio_pkg::mmio_req_t bus_req
);

    // one-entry deferral slot
    logic                pend_valid;
    mmio_pkg::mmio_req_t pend_req;

    // slot update for the next cycle
    logic                pend_load;
    mmio_pkg::mmio_req_t pend_next;

    // priority: pending, then core, then host
    always_comb begin
        bus_req = '0;
        pend_load = 1'b0;
        pend_next = host_req;
        if (pend_valid) begin
            bus_req = pend_req;
            // the stored master strobed last cycle, so at most one new strobe here
            if (core_req.strobe) begin
                pend_load = 1'b1;
                pend_next = core_req;
            end else if (host_req.strobe) begin
                pend_load = 1'b1;
            end
        end else if (core_req.strobe) begin
            bus_req = core_req;
            // collision, host goes next cycle
            pend_load = host_req.strobe;
        end else if (host_req.strobe) begin
            bus_req = host_req;
        end
    end

    // slot drains every cycle it is full
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= pend_load;
        end
    end

    // stored request keeps its own master tag
    always_ff @(posedge clk) begin
        if (pend_load) begin
            pend_req <= pend_next;
        end
    end

endmodule

/* rtl/mmio_decoder.sv */
module mmio_decoder (
    input  logic                                  clk,
    input  logic                                  reset,
    input  mmio_pkg::mmio_req_t                   bus_req,
    output mmio_pkg::mmio_rsp_t                   rsp,
    output logic                                  ram_we,
    output logic [mmio_pkg::ram_addr_width-1:0]   ram_addr,
    input  logic [mmio_pkg::data_width-1:0]       ram_rdata,
    input  logic [mmio_pkg::kb_width-1:0]         kb_data,
    input  logic                                  kb_ready,
    output logic                                  kb_pop,
    input  logic [mmio_pkg::swt_width-1:0]        swt,
    input  logic [mmio_pkg::rtc_width-1:0]        rtc_value,
    output logic                                  seg_we,
    output logic                                  led_we
);

    // region hits for the current bus address
    logic hit_ram;
    logic hit_kbd;
    logic hit_swt;
    logic hit_rtc;
    logic hit_seg;
    logic hit_led;
    logic hit_any;

    // bus qualifiers
    logic rd;
    logic wr;

    // non-ram read data, picked in the request cycle
    logic [mmio_pkg::data_width-1:0] rd_mux;

    // response registers
    logic                            rsp_valid_q;
    logic                            fault_q;
    logic                            ram_sel_q;
    mmio_pkg::master_t               master_q;
    logic [mmio_pkg::data_width-1:0] rdata_q;

    function automatic logic in_range(
        input logic [mmio_pkg::addr_width-1:0] addr,
        input logic [mmio_pkg::addr_width-1:0] base,
        input logic [mmio_pkg::addr_width-1:0] len
    );
        return (addr >= base) && (addr < base + len);
    endfunction

    assign hit_ram = in_range(bus_req.addr, mmio_pkg::ram_base, mmio_pkg::ram_len);
    assign hit_kbd = in_range(bus_req.addr, mmio_pkg::kbd_addr, mmio_pkg::periph_len);
    assign hit_swt = in_range(bus_req.addr, mmio_pkg::swt_addr, mmio_pkg::periph_len);
    assign hit_rtc = in_range(bus_req.addr, mmio_pkg::rtc_addr, mmio_pkg::periph_len);
    assign hit_seg = in_range(bus_req.addr, mmio_pkg::seg_addr, mmio_pkg::periph_len);
    assign hit_led = in_range(bus_req.addr, mmio_pkg::led_addr, mmio_pkg::periph_len);
    assign hit_any = hit_ram | hit_kbd | hit_swt | hit_rtc | hit_seg | hit_led;

    assign rd = bus_req.strobe & ~bus_req.write;
    assign wr = bus_req.strobe & bus_req.write;

    // write enables; kbd, swt and rtc are read-only and drop writes
    assign ram_we = wr & hit_ram;
    assign seg_we = wr & hit_seg;
    assign led_we = wr & hit_led;

    // doubleword index inside the ram region
    assign ram_addr = bus_req.addr[3 +: mmio_pkg::ram_addr_width];

    // pop only when a key is actually there
    assign kb_pop = rd & hit_kbd & kb_ready;

    // zero-extended sources; seg and led are write-only and read as zero
    always_comb begin
        rd_mux = '0;
        if (hit_kbd && kb_ready) begin
            rd_mux[mmio_pkg::kb_width-1:0] = kb_data;
        end else if (hit_swt) begin
            rd_mux[mmio_pkg::swt_width-1:0] = swt;
        end else if (hit_rtc) begin
            rd_mux[mmio_pkg::rtc_width-1:0] = rtc_value;
        end
    end

    // response control
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_q <= 1'b0;
            fault_q <= 1'b0;
            ram_sel_q <= 1'b0;
        end else begin
            rsp_valid_q <= rd;
            fault_q <= rd & ~hit_any;
            ram_sel_q <= rd & hit_ram;
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (rd) begin
            master_q <= bus_req.master;
            rdata_q <= rd_mux;
        end
    end

    // ram data arrives one cycle late, so pick it here
    always_comb begin
        rsp.valid = rsp_valid_q;
        rsp.fault = fault_q;
        rsp.master = master_q;
        rsp.rdata = ram_sel_q ? ram_rdata : rdata_q;
    end

endmodule

/* rtl/data_ram.sv */
module data_ram (
    input  logic                                clk,
    input  logic                                we,
    input  logic [mmio_pkg::ram_addr_width-1:0] addr,
    input  mmio_pkg::size_t                     size,
    input  logic [2:0]                          byte_off,
    input  logic [mmio_pkg::data_width-1:0]     wdata,
    output logic [mmio_pkg::data_width-1:0]     rdata
);

    logic [mmio_pkg::data_width-1:0] mem [mmio_pkg::ram_words];

    // lanes touched by this store
    logic [mmio_pkg::byte_lanes-1:0] size_mask;
    logic [mmio_pkg::byte_lanes-1:0] lane_mask;
    logic [mmio_pkg::data_width-1:0] lane_data;

    always_comb begin
        unique case (size)
            mmio_pkg::size_byte: size_mask = 8'b0000_0001;
            mmio_pkg::size_half: size_mask = 8'b0000_0011;
            mmio_pkg::size_word: size_mask = 8'b0000_1111;
            default:             size_mask = 8'b1111_1111;
        endcase
        // bytes past lane 7 fall off, no wrap
        lane_mask = size_mask << byte_off;
        // low bytes of wdata moved up to the first lane
        lane_data = wdata << {byte_off, 3'b000};
    end

    // per-lane write
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < mmio_pkg::byte_lanes; i++) begin
                if (lane_mask[i]) begin
                    mem[addr][i*8 +: 8] <= lane_data[i*8 +: 8];
                end
            end
        end
    end

    // full doubleword, registered
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

/* rtl/peripheral_regs.sv */
module peripheral_regs (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               seg_we,
    input  logic                               led_we,
    input  logic [mmio_pkg::data_width-1:0]    wdata,
    output logic [mmio_pkg::seg_width-1:0]     seg,
    output logic [mmio_pkg::led_width-1:0]     led,
    output logic [mmio_pkg::rtc_width-1:0]     rtc_value
);

    // prescaler, wraps every rtc_div clocks
    logic [$clog2(mmio_pkg::rtc_div)-1:0] presc;
    logic                                 tick;

    assign tick = (presc == $bits(presc)'(mmio_pkg::rtc_div - 1));

    // display registers take the low bits of the store
    always_ff @(posedge clk) begin
        if (reset) begin
            seg <= '0;
            led <= '0;
        end else begin
            if (seg_we) begin
                seg <= wdata[mmio_pkg::seg_width-1:0];
            end
            if (led_we) begin
                led <= wdata[mmio_pkg::led_width-1:0];
            end
        end
    end

    // free-running counter
    always_ff @(posedge clk) begin
        if (reset) begin
            presc <= '0;
            rtc_value <= '0;
        end else begin
            if (tick) begin
                presc <= '0;
                rtc_value <= rtc_value + 1'b1;
            end else begin
                presc <= presc + 1'b1;
            end
        end
    end

endmodule

/* rtl/mmio_subsystem.sv */
module mmio_subsystem (
    input  logic                            clk,
    input  logic                            reset,
    input  mmio_pkg::mmio_req_t             core_req,
    input  mmio_pkg::mmio_req_t             host_req,
    output mmio_pkg::mmio_rsp_t             rsp,
    input  logic [mmio_pkg::kb_width-1:0]   kb_data,
    input  logic                            kb_ready,
    output logic                            kb_pop,
    input  logic [mmio_pkg::swt_width-1:0]  swt,
    output logic [mmio_pkg::seg_width-1:0]  seg,
    output logic [mmio_pkg::led_width-1:0]  led
);

    // shared bus after arbitration
    mmio_pkg::mmio_req_t bus_req;

    // ram side
    logic                                ram_we;
    logic [mmio_pkg::ram_addr_width-1:0] ram_addr;
    logic [mmio_pkg::data_width-1:0]     ram_rdata;

    // peripheral side
    logic                                seg_we;
    logic                                led_we;
    logic [mmio_pkg::rtc_width-1:0]      rtc_value;

    bus_arbiter u_arbiter (
        .clk      (clk),
        .reset    (reset),
        .core_req (core_req),
        .host_req (host_req),
        .bus_req  (bus_req)
    );

    mmio_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .rsp       (rsp),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_rdata (ram_rdata),
        .kb_data   (kb_data),
        .kb_ready  (kb_ready),
        .kb_pop    (kb_pop),
        .swt       (swt),
        .rtc_value (rtc_value),
        .seg_we    (seg_we),
        .led_we    (led_we)
    );

    // store size and lane offset straight off the bus
    data_ram u_ram (
        .clk      (clk),
        .we       (ram_we),
        .addr     (ram_addr),
        .size     (bus_req.size),
        .byte_off (bus_req.addr[2:0]),
        .wdata    (bus_req.wdata),
        .rdata    (ram_rdata)
    );

    peripheral_regs u_periph (
        .clk       (clk),
        .reset     (reset),
        .seg_we    (seg_we),
        .led_we    (led_we),
        .wdata     (bus_req.wdata),
        .seg       (seg),
        .led       (led),
        .rtc_value (rtc_value)
    );

endmodule

/* bench/mmio_assertions.sv */
module mmio_assertions (
    input logic clk,
    input logic reset,
    input logic core_strobe,
    input logic host_strobe,
    input logic pend_valid,
    input logic pend_load,
    input logic bus_read,
    input logic rsp_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // each master idles at least one cycle between strobes
    core_gap: assert property (@(posedge clk) disable iff (reset) core_strobe |=> !core_strobe)
        else begin
            fail_count++;
            $error("core strobed in consecutive cycles");
        end

    host_gap: assert property (@(posedge clk) disable iff (reset) host_strobe |=> !host_strobe)
        else begin
            fail_count++;
            $error("host strobed in consecutive cycles");
        end

    // slot drains before it loads again
    pend_no_overwrite: assert property (@(posedge clk) disable iff (reset)
        pend_valid |-> !pend_load)
        else begin
            fail_count++;
            $error("pending request overwritten");
        end

    // read answers exactly one cycle later
    read_response: assert property (@(posedge clk) disable iff (reset) bus_read |=> rsp_valid)
        else begin
            fail_count++;
            $error("read got no response one cycle after the bus request");
        end

endmodule

bind bus_arbiter mmio_assertions arbiter_checks (
    .clk         (clk),
    .reset       (reset),
    .core_strobe (core_req.strobe),
    .host_strobe (host_req.strobe),
    .pend_valid  (pend_valid),
    .pend_load   (pend_load),
    .bus_read    (1'b0),
    .rsp_valid   (1'b0)
);

bind mmio_decoder mmio_assertions decoder_checks (
    .clk         (clk),
    .reset       (reset),
    .core_strobe (1'b0),
    .host_strobe (1'b0),
    .pend_valid  (1'b0),
    .pend_load   (1'b0),
    .bus_read    (bus_req.strobe & ~bus_req.write),
    .rsp_valid   (rsp.valid)
);

/* bench/mmio_tb.sv */
module mmio_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // ram reads stay inside a prefilled window so no word is ever unknown
    localparam int ram_window = 32;
    localparam int steps = 300;
    localparam int stim_cycles = ram_window * 2 + steps * 3;
    localparam int timeout_limit = 2 * stim_cycles + 100;

    typedef struct packed {
        logic [mmio_pkg::data_width-1:0] data;
        logic                            fault;
        logic                            is_rtc;
    } expect_t;

    logic                           clk;
    logic                           reset;
    mmio_pkg::mmio_req_t            core_req;
    mmio_pkg::mmio_req_t            host_req;
    mmio_pkg::mmio_rsp_t            rsp;
    logic [mmio_pkg::kb_width-1:0]  kb_data;
    logic                           kb_ready;
    logic                           kb_pop;
    logic [mmio_pkg::swt_width-1:0] swt;
    logic [mmio_pkg::seg_width-1:0] seg;
    logic [mmio_pkg::led_width-1:0] led;

    // reference model state
    logic [mmio_pkg::data_width-1:0] shadow_ram [ram_window];
    logic [mmio_pkg::seg_width-1:0]  shadow_seg;
    logic [mmio_pkg::led_width-1:0]  shadow_led;
    logic [mmio_pkg::kb_width-1:0]   kb_data_v;
    logic                            kb_ready_v;
    logic [mmio_pkg::swt_width-1:0]  swt_v;
    expect_t                         core_q [$];
    expect_t                         host_q [$];
    mmio_pkg::master_t               order_q [$];

    logic [31:0]       lcg_state = 32'ha3be;
    int                error_count = 0;
    int                checks = 0;
    int                cycle_count = 0;
    int                pops = 0;
    int                expected_pops = 0;
    logic              rtc_seen = 1'b0;
    logic [31:0]       last_rtc;
    int                last_rtc_cycle;
    expect_t           got;
    mmio_pkg::master_t want_master;

    mmio_subsystem UUT (
        .clk      (clk),
        .reset    (reset),
        .core_req (core_req),
        .host_req (host_req),
        .rsp      (rsp),
        .kb_data  (kb_data),
        .kb_ready (kb_ready),
        .kb_pop   (kb_pop),
        .swt      (swt),
        .seg      (seg),
        .led      (led)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // store into the shadow state, lanes from size and offset
    function automatic void apply_write(input logic [15:0] addr, input mmio_pkg::size_t size,
                                        input logic [63:0] wdata);
        int nbytes;
        nbytes = 1 << size;
        if (addr < mmio_pkg::ram_len) begin
            for (int i = 0; i < nbytes; i++) begin
                shadow_ram[addr[7:3]][(addr[2:0] + i) * 8 +: 8] = wdata[i * 8 +: 8];
            end
        end else if (addr == mmio_pkg::seg_addr) begin
            shadow_seg = wdata[mmio_pkg::seg_width-1:0];
        end else if (addr == mmio_pkg::led_addr) begin
            shadow_led = wdata[mmio_pkg::led_width-1:0];
        end
    endfunction

    // expected read data and fault, zero-extended
    function automatic expect_t expected_read(input logic [15:0] addr);
        expect_t e;
        e = '0;
        if (addr < mmio_pkg::ram_len) begin
            e.data = shadow_ram[addr[7:3]];
        end else if (addr == mmio_pkg::kbd_addr) begin
            if (kb_ready_v) begin
                e.data = 64'(kb_data_v);
            end
        end else if (addr == mmio_pkg::swt_addr) begin
            e.data = 64'(swt_v);
        end else if (addr == mmio_pkg::rtc_addr) begin
            // rtc only gets a bound check
            e.is_rtc = 1'b1;
        end else begin
            e.fault = 1'b1;
        end
        return e;
    endfunction

    task automatic make_request(input mmio_pkg::master_t m, output mmio_pkg::mmio_req_t r);
        logic [31:0] sel;
        logic [3:0]  kind;
        logic [2:0]  off;
        sel = next_random();
        kind = sel[31:28];
        // natural alignment for the store size
        off = sel[20:18] & (3'b111 << sel[27:26]);
        r = '0;
        r.strobe = 1'b1;
        r.master = m;
        r.size = mmio_pkg::size_t'(sel[27:26]);
        r.wdata = {next_random(), next_random()};
        if (kind < 4'd6) begin
            r.write = 1'b1;
            r.addr = {8'h00, sel[25:21], off};
        end else if (kind < 4'd9) begin
            r.addr = {8'h00, sel[25:21], 3'b000};
            r.size = mmio_pkg::size_dword;
        end else begin
            case (kind)
                4'd9:    r.addr = mmio_pkg::kbd_addr;
                4'd10:   r.addr = mmio_pkg::swt_addr;
                4'd11:   r.addr = mmio_pkg::rtc_addr;
                4'd12:   r.addr = mmio_pkg::seg_addr;
                4'd13:   r.addr = mmio_pkg::led_addr;
                default: r.addr = 16'h1028 + 16'(sel[11:0]);
            endcase
            // seg, led and the odd unmapped slot are stores
            r.write = (kind == 4'd12) || (kind == 4'd13) || (kind == 4'd15);
        end
    endtask

    // update the model in bus order, core before host
    task automatic issue(input mmio_pkg::mmio_req_t r);
        expect_t e;
        if (r.strobe) begin
            if (r.write) begin
                apply_write(r.addr, r.size, r.wdata);
            end else begin
                e = expected_read(r.addr);
                order_q.push_back(r.master);
                if (r.master == mmio_pkg::master_core) begin
                    core_q.push_back(e);
                end else begin
                    host_q.push_back(e);
                end
                if (r.addr == mmio_pkg::kbd_addr && kb_ready_v) begin
                    expected_pops++;
                end
            end
        end
    endtask

    task automatic prefill();
        mmio_pkg::mmio_req_t r;
        for (int i = 0; i < ram_window; i++) begin
            r = '0;
            r.strobe = 1'b1;
            r.write = 1'b1;
            r.size = mmio_pkg::size_dword;
            r.addr = 16'(i * 8);
            r.wdata = {next_random(), ~r.addr, r.addr};
            issue(r);
            @(posedge clk);
            core_req <= r;
            @(posedge clk);
            core_req <= '0;
        end
    endtask

    // one strobe cycle, two idle cycles, then the display check
    task automatic run_step();
        mmio_pkg::mmio_req_t c;
        mmio_pkg::mmio_req_t h;
        logic [31:0]         mode;
        mode = next_random();
        kb_ready_v = mode[16];
        kb_data_v = mode[31:24];
        swt_v = mode[23:17] ^ mode[7:0];
        c = '0;
        h = '0;
        // modes 0 and 3 collide
        if (mode[1:0] != 2'd2) begin
            make_request(mmio_pkg::master_core, c);
        end
        if (mode[1:0] != 2'd1) begin
            make_request(mmio_pkg::master_host, h);
        end
        issue(c);
        issue(h);
        @(posedge clk);
        core_req <= c;
        host_req <= h;
        kb_ready <= kb_ready_v;
        kb_data <= kb_data_v;
        swt <= swt_v;
        @(posedge clk);
        core_req <= '0;
        host_req <= '0;
        @(posedge clk);
        @(negedge clk);
        if (seg !== shadow_seg) begin
            error_count++;
            $display("FAILED at %0t: seg %h, expected %h", $time, seg, shadow_seg);
        end
        if (led !== shadow_led) begin
            error_count++;
            $display("FAILED at %0t: led %h, expected %h", $time, led, shadow_led);
        end
    endtask

    // compare process, outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && kb_pop === 1'b1) begin
            pops++;
        end
        if (!reset && rsp.valid === 1'b1) begin
            checks++;
            if (order_q.size() == 0) begin
                error_count++;
                $display("response at %0t arrived with no read outstanding", $time);
            end else begin
                want_master = order_q.pop_front();
                got = (want_master == mmio_pkg::master_core) ? core_q.pop_front()
                                                             : host_q.pop_front();
                if (rsp.master !== want_master) begin
                    error_count++;
                    $display("FAILED at %0t: master %0d, expected %0d", $time,
                             rsp.master, want_master);
                end
                if (rsp.fault !== got.fault) begin
                    error_count++;
                    $display("FAILED at %0t: fault %b, expected %b", $time, rsp.fault, got.fault);
                end
                if (got.is_rtc) begin
                    if (rsp.rdata[63:32] !== 32'h0) begin
                        error_count++;
                        $display("FAILED at %0t: rtc upper bits %h", $time, rsp.rdata[63:32]);
                    end else if (rtc_seen && rsp.rdata[31:0] < last_rtc) begin
                        error_count++;
                        $display("FAILED at %0t: rtc went back from %0d to %0d", $time,
                                 last_rtc, rsp.rdata[31:0]);
                    end else if (rtc_seen && rsp.rdata[31:0] - last_rtc >
                                 32'((cycle_count - last_rtc_cycle) / mmio_pkg::rtc_div + 1)) begin
                        error_count++;
                        $display("FAILED at %0t: rtc jumped from %0d to %0d", $time,
                                 last_rtc, rsp.rdata[31:0]);
                    end else if (rtc_seen && rsp.rdata[31:0] - last_rtc + 32'd1 <
                                 32'((cycle_count - last_rtc_cycle) / mmio_pkg::rtc_div)) begin
                        error_count++;
                        $display("FAILED at %0t: rtc advanced too little from %0d to %0d",
                                 $time, last_rtc, rsp.rdata[31:0]);
                    end
                    rtc_seen = 1'b1;
                    last_rtc = rsp.rdata[31:0];
                    last_rtc_cycle = cycle_count;
                end else if (rsp.rdata !== got.data) begin
                    error_count++;
                    $display("FAILED at %0t: rdata %h, expected %h", $time, rsp.rdata, got.data);
                end
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        core_req = '0;
        host_req = '0;
        kb_data = '0;
        kb_ready = 1'b0;
        swt = '0;
        shadow_seg = '0;
        shadow_led = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        prefill();
        repeat (steps) run_step();
        while (order_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (pops != expected_pops) begin
            error_count++;
            $display("FAILED at %0t: kb_pop count %0d, expected %0d", $time, pops, expected_pops);
        end
        error_count += UUT.u_arbiter.arbiter_checks.fail_count;
        error_count += UUT.u_decoder.decoder_checks.fail_count;
        $display("responses checked %0d, kb pops %0d, errors %0d", checks, pops, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* project.f */
rtl/mmio_pkg.sv
rtl/bus_arbiter.sv
rtl/mmio_decoder.sv
rtl/data_ram.sv
rtl/peripheral_regs.sv
rtl/mmio_subsystem.sv
bench/mmio_assertions.sv
bench/mmio_tb.sv

/* Bender.yml */
package:
  name: mmio_subsystem

sources:
  - rtl/mmio_pkg.sv
  - rtl/bus_arbiter.sv
  - rtl/mmio_decoder.sv
  - rtl/data_ram.sv
  - rtl/peripheral_regs.sv
  - rtl/mmio_subsystem.sv
  - target: test
    files:
      - bench/mmio_assertions.sv
      - bench/mmio_tb.sv
